// File: Makefile
# Verilator build and run for the token engine

VERILATOR ?= verilator
TOP       ?= tb_token_engine
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "result: failed"; exit 1; fi
	@if ! grep -q "TEST PASS" $(LOG); then echo "result: no pass line in $(LOG)"; exit 1; fi
	@echo "result: passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: pass_cfg_if.sv
// latched pass configuration bus
`timescale 1ns/10ps

interface pass_cfg_if import te_params_pkg::*; ();

    logic [CNT_WIDTH-1:0]  tile_k;       // weight / bias words
    logic [CNT_WIDTH-1:0]  ifmap_packs;  // packs per row
    logic                  bias_en;
    logic [DIM_WIDTH-1:0]  out_c;        // psum words per row
    logic [DIM_WIDTH-1:0]  out_r;        // rows per pass
    logic [ADDR_WIDTH-1:0] base_weight;
    logic [ADDR_WIDTH-1:0] base_bias;
    logic [ADDR_WIDTH-1:0] base_ifmap;
    logic [ADDR_WIDTH-1:0] base_opsum;

    // config register side
    modport cfg_src (
        output tile_k, ifmap_packs, bias_en, out_c, out_r,
        output base_weight, base_bias, base_ifmap, base_opsum
    );

    // token reads and pushes
    modport seq_sink (
        input tile_k, ifmap_packs, bias_en, out_r,
        input base_weight, base_bias, base_ifmap
    );

    // psum writeback only needs row width and target base
    modport wb_sink (
        input out_c, base_opsum
    );

endinterface

// File: pass_config.sv
// pass parameter latch
`timescale 1ns/10ps

module pass_config import te_params_pkg::*, te_types_pkg::*; (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  pass_start,       // 1-cycle strobe
    input  logic                  pass_done,        // closes the pass
    input  layer_type_e           pass_layer_type,
    input  logic [FLAG_WIDTH-1:0] pass_flags,
    input  logic [DIM_WIDTH-1:0]  out_c,
    input  logic [DIM_WIDTH-1:0]  out_r,
    input  logic [ADDR_WIDTH-1:0] base_weight,
    input  logic [ADDR_WIDTH-1:0] base_bias,
    input  logic [ADDR_WIDTH-1:0] base_ifmap,
    input  logic [ADDR_WIDTH-1:0] base_opsum,
    pass_cfg_if.cfg_src           cfg
);

    logic                 busy;        // pass in flight, mirrors sequencer != idle
    logic                 load;
    logic [CNT_WIDTH-1:0] tile_k_sel;
    logic [CNT_WIDTH-1:0] packs_sel;

    assign load = pass_start && !busy;  // start during a pass is dropped

    // layer type -> tile sizes
    always_comb begin
        case (pass_layer_type)
            layer_pointwise: begin
                tile_k_sel = TILE_K_POINTWISE;
                packs_sel  = IFMAP_PACKS_POINTWISE;
            end
            layer_depthwise: begin
                tile_k_sel = TILE_K_DEPTHWISE;
                packs_sel  = IFMAP_PACKS_DEPTHWISE;
            end
            layer_conv, layer_reserved: begin
                tile_k_sel = TILE_K_CONV;
                packs_sel  = IFMAP_PACKS_CONV;
            end
            default: begin
                tile_k_sel = TILE_K_CONV;
                packs_sel  = IFMAP_PACKS_CONV;
            end
        endcase
    end

    // ========================================
    // control fields
    // ========================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            busy            <= 1'b0;
            cfg.tile_k      <= '0;
            cfg.ifmap_packs <= '0;
            cfg.bias_en     <= 1'b0;
            cfg.out_c       <= '0;
            cfg.out_r       <= '0;
        end else begin
            if (load) begin
                busy            <= 1'b1;
                cfg.tile_k      <= tile_k_sel;
                cfg.ifmap_packs <= packs_sel;
                cfg.bias_en     <= pass_flags[FLAG_BIAS_EN];
                cfg.out_c       <= out_c;
                cfg.out_r       <= out_r;
            end else if (pass_done) begin
                busy <= 1'b0;  // sequencer back in idle next cycle
            end
        end
    end

    // base addresses, plain data
    always_ff @(posedge clk) begin
        if (load) begin
            cfg.base_weight <= base_weight;
            cfg.base_bias   <= base_bias;
            cfg.base_ifmap  <= base_ifmap;
            cfg.base_opsum  <= base_opsum;
        end
    end

endmodule

// File: psum_writeback.sv
// partial sum pop and glb writeback
`timescale 1ns/10ps

module psum_writeback import te_params_pkg::*, te_types_pkg::*; (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  row_start,     // from sequencer
    input  logic                  pass_done,     // rearms the opsum pointer
    pass_cfg_if.wb_sink           cfg,
    // psum buffer pop
    input  logic [DATA_WIDTH-1:0] pe_psum_data,
    input  logic                  pe_psum_valid,
    output logic                  pe_psum_ready,
    // glb write
    output logic [ADDR_WIDTH-1:0] glb_write_addr,
    output logic [DATA_WIDTH-1:0] glb_write_data,
    output logic                  glb_write_ready,
    input  logic                  glb_write_valid,
    output logic                  row_done
);

    wb_state_e             state;
    wb_state_e             state_nxt;
    logic [DIM_WIDTH-1:0]  col_cnt;
    logic [ADDR_WIDTH-1:0] opsum_cnt;  // words written since pass start
    logic                  first_row;
    logic                  col_last;

    assign col_last = (col_cnt == cfg.out_c - 1'b1);

    always_comb begin
        state_nxt = state;
        case (state)
            wb_idle:  if (row_start) state_nxt = wb_pop;
            wb_pop:   if (pe_psum_valid) state_nxt = wb_write;
            wb_write: if (glb_write_valid) state_nxt = col_last ? wb_idle : wb_pop;
            default:  state_nxt = wb_idle;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state     <= wb_idle;
            col_cnt   <= '0;
            opsum_cnt <= '0;
            first_row <= 1'b1;
        end else begin
            state <= state_nxt;
            if (pass_done) begin
                first_row <= 1'b1;
            end else if ((state == wb_idle) && row_start) begin
                first_row <= 1'b0;
                col_cnt   <= '0;
                if (first_row) opsum_cnt <= '0;  // new pass, restart at base_opsum
            end else if ((state == wb_write) && glb_write_valid) begin
                col_cnt   <= col_cnt + 1'b1;
                opsum_cnt <= opsum_cnt + 1'b1;
            end
        end
    end

    // popped word, held through the write
    always_ff @(posedge clk) begin
        if (pe_psum_ready) glb_write_data <= pe_psum_data;
    end

    assign pe_psum_ready   = (state == wb_pop) && pe_psum_valid;
    assign glb_write_ready = (state == wb_write);
    assign glb_write_addr  = cfg.base_opsum + opsum_cnt;
    // same edge as last ack, so pass_done follows one cycle later
    assign row_done        = (state == wb_write) && glb_write_valid && col_last;

endmodule

// File: sources.f
te_params_pkg.sv
te_types_pkg.sv
pass_cfg_if.sv
pass_config.sv
token_sequencer.sv
psum_writeback.sv
token_engine_top.sv
tb_token_engine.sv

// File: tb_token_engine.sv
// token engine testbench
`timescale 1ns/10ps

module tb_token_engine import te_params_pkg::*, te_types_pkg::*; ();

    localparam logic [31:0] SEED   = 32'h7850_7dcb;
    localparam int NUM_PASSES      = 12;
    localparam int HALF_PERIOD     = 10;          // 20 ns clock
    localparam int MAX_DELAY       = 3;           // glb ack delay in cycles
    localparam int WORST_WORDS     = 2*32 + 4*8 + 4*4;  // pointwise with bias and 4 x 4 output
    localparam int CYCLES_PER_WORD = 4 * (MAX_DELAY + 2);
    localparam int TIMEOUT_NS      = NUM_PASSES * WORST_WORDS * CYCLES_PER_WORD * 2 * HALF_PERIOD;

    localparam logic [1:0] CH_WEIGHT = 2'd0;
    localparam logic [1:0] CH_BIAS   = 2'd1;
    localparam logic [1:0] CH_IFMAP  = 2'd2;

    // dut inputs start quiet
    logic                  clk             = 1'b0;
    logic                  reset_n         = 1'b0;
    logic                  pass_start      = 1'b0;
    layer_type_e           pass_layer_type = layer_conv;
    logic [FLAG_WIDTH-1:0] pass_flags      = '0;
    logic [DIM_WIDTH-1:0]  out_c           = '0;
    logic [DIM_WIDTH-1:0]  out_r           = '0;
    logic [ADDR_WIDTH-1:0] base_weight     = '0;
    logic [ADDR_WIDTH-1:0] base_bias       = '0;
    logic [ADDR_WIDTH-1:0] base_ifmap      = '0;
    logic [ADDR_WIDTH-1:0] base_opsum      = '0;
    logic                  glb_read_valid  = 1'b0;
    logic [DATA_WIDTH-1:0] glb_read_data   = '0;
    logic                  glb_write_valid = 1'b0;
    logic                  pe_weight_ready = 1'b0;
    logic                  pe_bias_ready   = 1'b0;
    logic                  pe_ifmap_ready  = 1'b0;
    logic [DATA_WIDTH-1:0] pe_psum_data    = '0;
    logic                  pe_psum_valid   = 1'b0;

    // dut outputs
    logic [ADDR_WIDTH-1:0] glb_read_addr;
    logic                  glb_read_ready;
    logic [ADDR_WIDTH-1:0] glb_write_addr;
    logic [DATA_WIDTH-1:0] glb_write_data;
    logic                  glb_write_ready;
    logic [DATA_WIDTH-1:0] token_data;
    logic                  pe_weight_valid;
    logic                  pe_bias_valid;
    logic                  pe_ifmap_valid;
    logic                  pe_psum_ready;
    logic                  pass_done;

    // one rng stream per process
    logic [31:0] rng_main = SEED;
    logic [31:0] rng_rd   = SEED ^ 32'h0000_1111;
    logic [31:0] rng_wr   = SEED ^ 32'h0022_2200;
    logic [31:0] rng_pe   = SEED ^ 32'h3300_0033;
    logic [31:0] rng_ps   = SEED ^ 32'h4444_0000;
    logic [1:0]  rd_wait  = 2'd0;
    logic [1:0]  wr_wait  = 2'd0;

    // expected pass from the stimulus
    logic [1:0]            exp_chan[$];
    logic [ADDR_WIDTH-1:0] exp_addr[$];
    logic [31:0]           pass_salt      = '0;
    logic [ADDR_WIDTH-1:0] cur_base_opsum = '0;
    int                    cur_packs      = 1;
    int                    cur_out_c      = 1;
    int                    exp_writes     = 0;

    // monitor bookkeeping
    logic [DATA_WIDTH-1:0] psum_q[$];    // popped but not yet written
    int                    tok_idx      = 0;
    int                    ifmap_pushed = 0;
    int                    writes_done  = 0;
    int                    done_count   = 0;
    logic                  done_pending = 1'b0;

    token_engine_top dut0 (.*);

    always #(HALF_PERIOD) clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // glb contents mix the address with the pass salt
    function automatic logic [DATA_WIDTH-1:0] glb_word(input logic [ADDR_WIDTH-1:0] addr);
        return {addr, ~addr} ^ pass_salt;
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string msg);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t: %s (got %h, expected %h)", $time, msg,
                     actual, expected);
            $display("TEST FAIL");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic report_error(input string msg);
        $display("error at %0t: %s", $time, msg);
        $display("TEST FAIL");
        $fatal(1, "stopped at first error");
    endtask

    // called on a rising edge and drops pass_start one edge later
    task automatic launch_pass(input layer_type_e lt, input logic [FLAG_WIDTH-1:0] flags,
                               input logic [DIM_WIDTH-1:0] rows, input logic [DIM_WIDTH-1:0] cols,
                               input logic [ADDR_WIDTH-1:0] bw, input logic [ADDR_WIDTH-1:0] bb,
                               input logic [ADDR_WIDTH-1:0] bi, input logic [ADDR_WIDTH-1:0] bo);
        pass_layer_type <= lt;
        pass_flags      <= flags;
        out_r           <= rows;
        out_c           <= cols;
        base_weight     <= bw;
        base_bias       <= bb;
        base_ifmap      <= bi;
        base_opsum      <= bo;
        pass_start      <= 1'b1;
        @(posedge clk);
        pass_start      <= 1'b0;
    endtask

    // ========================================
    // partner models
    // ========================================
    always @(posedge clk) begin
        if (glb_read_valid) begin
            glb_read_valid <= 1'b0;             // one-cycle ack
            glb_read_data  <= ~glb_read_data;   // junk outside the ack
        end else if (glb_read_ready) begin
            if (rd_wait == 2'd0) begin
                glb_read_valid <= 1'b1;
                glb_read_data  <= glb_word(glb_read_addr);
                rng_rd = xorshift32(rng_rd);
                rd_wait <= rng_rd[1:0];          // delay for the next request
            end else begin
                rd_wait <= rd_wait - 2'd1;
            end
        end
    end

    always @(posedge clk) begin
        if (glb_write_valid) begin
            glb_write_valid <= 1'b0;
        end else if (glb_write_ready) begin
            if (wr_wait == 2'd0) begin
                glb_write_valid <= 1'b1;
                rng_wr = xorshift32(rng_wr);
                wr_wait <= rng_wr[1:0];
            end else begin
                wr_wait <= wr_wait - 2'd1;
            end
        end
    end

    // pe readies drop about one cycle in four
    always @(posedge clk) begin
        rng_pe = xorshift32(rng_pe);
        pe_weight_ready <= (rng_pe[1:0] != 2'b00);
        pe_bias_ready   <= (rng_pe[3:2] != 2'b00);
        pe_ifmap_ready  <= (rng_pe[5:4] != 2'b00);
    end

    // psum buffer holds each word until taken
    always @(posedge clk) begin
        if (!pe_psum_valid || pe_psum_ready) begin
            rng_ps = xorshift32(rng_ps);
            pe_psum_data  <= rng_ps;
            pe_psum_valid <= (rng_ps[1:0] != 2'b00);
        end
    end

    // ========================================
    // monitor and checks
    // ========================================
    always @(posedge clk) begin : monitor
        logic [1:0]            chan;
        logic [ADDR_WIDTH-1:0] waddr;
        logic                  last_ack;
        int                    row;
        last_ack = 1'b0;
        if (reset_n) begin
            check_value(32'($onehot0({pe_weight_valid, pe_bias_valid, pe_ifmap_valid})),
                        32'd1, "more than one push valid");
            if (glb_read_ready && glb_read_valid) begin
                if (tok_idx >= exp_chan.size()) begin
                    report_error("GLB read after the last expected token");
                end else begin
                    check_value(32'(glb_read_addr), 32'(exp_addr[tok_idx]), "read address");
                end
            end
            if ((pe_weight_valid && pe_weight_ready) || (pe_bias_valid && pe_bias_ready) ||
                (pe_ifmap_valid && pe_ifmap_ready)) begin
                chan = pe_weight_valid ? CH_WEIGHT : (pe_bias_valid ? CH_BIAS : CH_IFMAP);
                if (tok_idx >= exp_chan.size()) begin
                    report_error("PE push after the last expected token");
                end else begin
                    check_value(32'(chan), 32'(exp_chan[tok_idx]), "push channel");
                    check_value(token_data, glb_word(exp_addr[tok_idx]), "token data");
                    if (chan == CH_IFMAP) begin
                        row = ifmap_pushed / cur_packs;
                        // previous row has to be written back first
                        check_value(32'(writes_done >= row * cur_out_c), 32'd1,
                                    "ifmap pushed before previous row written");
                        ifmap_pushed++;
                    end
                    tok_idx++;
                end
            end
            if (pe_psum_valid && pe_psum_ready) psum_q.push_back(pe_psum_data);
            if (glb_write_ready && glb_write_valid) begin
                if (psum_q.size() == 0) begin
                    report_error("GLB write without a popped partial sum");
                end else begin
                    waddr = cur_base_opsum + ADDR_WIDTH'(writes_done);
                    check_value(32'(glb_write_addr), 32'(waddr), "write address");
                    check_value(glb_write_data, psum_q.pop_front(), "write data");
                    check_value(32'(writes_done < (ifmap_pushed / cur_packs) * cur_out_c),
                                32'd1, "more than out_c writes for a row");
                    writes_done++;
                    last_ack = (writes_done == exp_writes);
                end
            end
            check_value(32'(pass_done), 32'(done_pending), "pass_done timing");
            if (pass_done) begin
                check_value(32'({glb_read_ready, glb_write_ready, pe_weight_valid,
                                 pe_bias_valid, pe_ifmap_valid, pe_psum_ready}),
                            32'd0, "request outstanding during pass_done");
                check_value(32'(tok_idx), 32'(exp_chan.size()), "tokens pushed per pass");
                check_value(32'(psum_q.size()), 32'd0, "popped words left unwritten");
                done_count++;
                tok_idx      = 0;
                ifmap_pushed = 0;
                writes_done  = 0;
            end
            done_pending = last_ack;  // last ack -> pass_done next cycle
        end
    end

    // ========================================
    // stimulus
    // ========================================
    initial begin : stimulus
        layer_type_e           lt;
        logic [FLAG_WIDTH-1:0] flags;
        logic [DIM_WIDTH-1:0]  rows;
        logic [DIM_WIDTH-1:0]  cols;
        logic [ADDR_WIDTH-1:0] bw;
        logic [ADDR_WIDTH-1:0] bb;
        logic [ADDR_WIDTH-1:0] bi;
        logic [ADDR_WIDTH-1:0] bo;
        int                    tile_k;
        repeat (3) @(posedge clk);
        reset_n <= 1'b1;
        // quiet outputs before any pass
        repeat (4) begin
            @(posedge clk);
            check_value(32'({glb_read_ready, glb_write_ready, pe_weight_valid, pe_bias_valid,
                             pe_ifmap_valid, pe_psum_ready, pass_done}),
                        32'd0, "output active before first pass_start");
        end
        for (int p = 0; p < NUM_PASSES; p++) begin
            rng_main = xorshift32(rng_main);
            lt    = layer_type_e'(rng_main[1:0]);
            flags = rng_main[7:4];
            rows  = DIM_WIDTH'(rng_main[9:8]) + 7'd1;    // 1 to 4
            cols  = DIM_WIDTH'(rng_main[11:10]) + 7'd1;
            rng_main = xorshift32(rng_main);
            bw = rng_main[15:0];
            bb = rng_main[31:16];
            rng_main = xorshift32(rng_main);
            bi = rng_main[15:0];
            bo = rng_main[31:16];
            rng_main  = xorshift32(rng_main);
            pass_salt = rng_main;
            case (lt)
                layer_pointwise: begin
                    tile_k    = 32;
                    cur_packs = 8;
                end
                layer_depthwise: begin
                    tile_k    = 10;
                    cur_packs = 3;
                end
                default: begin  // conv and reserved
                    tile_k    = 16;
                    cur_packs = 8;
                end
            endcase
            // expected token stream
            exp_chan.delete();
            exp_addr.delete();
            for (int i = 0; i < tile_k; i++) begin
                exp_chan.push_back(CH_WEIGHT);
                exp_addr.push_back(bw + ADDR_WIDTH'(i));
            end
            if (flags[FLAG_BIAS_EN]) begin
                for (int i = 0; i < tile_k; i++) begin
                    exp_chan.push_back(CH_BIAS);
                    exp_addr.push_back(bb + ADDR_WIDTH'(i));
                end
            end
            for (int i = 0; i < int'(rows) * cur_packs; i++) begin
                exp_chan.push_back(CH_IFMAP);
                exp_addr.push_back(bi + ADDR_WIDTH'(i));  // runs on across rows
            end
            cur_out_c      = int'(cols);
            cur_base_opsum = bo;
            exp_writes     = int'(rows) * int'(cols);
            launch_pass(lt, flags, rows, cols, bw, bb, bi, bo);
            repeat (6) @(posedge clk);
            // dut busy so this start must change nothing
            launch_pass(layer_type_e'(~lt), ~flags, 7'd5, 7'd6, ~bw, ~bb, ~bi, ~bo);
            while (done_count <= p) @(posedge clk);
            repeat (3) @(posedge clk);
        end
        $display("TEST PASS");
        $finish;
    end

    // watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("timeout: %0d passes did not finish within %0d ns", NUM_PASSES, TIMEOUT_NS);
        $display("TEST FAIL");
        $fatal(1, "watchdog expired");
    end

endmodule

// File: te_params_pkg.sv
// token engine widths and tile sizes
package te_params_pkg;

    // ========================================
    // bus and counter widths
    // ========================================
    localparam int ADDR_WIDTH = 16;  // glb word address
    localparam int DATA_WIDTH = 32;  // glb / pe word
    localparam int DIM_WIDTH  = 7;   // out_r, out_c
    localparam int CNT_WIDTH  = 6;   // token counts, up to 63
    localparam int FLAG_WIDTH = 4;   // pass flags

    // ========================================
    // tile sizes per layer type
    // ========================================
    // weight and bias words per pass
    localparam logic [CNT_WIDTH-1:0] TILE_K_CONV      = CNT_WIDTH'(16);
    localparam logic [CNT_WIDTH-1:0] TILE_K_POINTWISE = CNT_WIDTH'(32);
    localparam logic [CNT_WIDTH-1:0] TILE_K_DEPTHWISE = CNT_WIDTH'(10);

    // ifmap packs per output row, four channels each
    localparam logic [CNT_WIDTH-1:0] IFMAP_PACKS_CONV      = CNT_WIDTH'(8);
    localparam logic [CNT_WIDTH-1:0] IFMAP_PACKS_POINTWISE = CNT_WIDTH'(8);
    localparam logic [CNT_WIDTH-1:0] IFMAP_PACKS_DEPTHWISE = CNT_WIDTH'(3);

endpackage

// File: te_types_pkg.sv
// token engine enums and flag index
package te_types_pkg;

    // layer type code from the layer decoder
    typedef enum logic [1:0] {
        layer_conv      = 2'b00,
        layer_pointwise = 2'b01,
        layer_depthwise = 2'b10,
        layer_reserved  = 2'b11   // runs as conv
    } layer_type_e;

    // sequencer FSM
    typedef enum logic [3:0] {
        seq_idle,
        seq_read_weight,
        seq_push_weight,
        seq_read_bias,
        seq_push_bias,
        seq_read_ifmap,
        seq_push_ifmap,
        seq_wait_row,    // writeback drains the row
        seq_pass_done
    } seq_state_e;

    // writeback FSM
    typedef enum logic [1:0] {
        wb_idle,
        wb_pop,
        wb_write
    } wb_state_e;

    localparam int FLAG_BIAS_EN = 0;  // pass_flags bit

endpackage

// File: token_engine_top.sv
// token engine top level
`timescale 1ns/10ps

module token_engine_top import te_params_pkg::*, te_types_pkg::*; (
    input  logic                  clk,
    input  logic                  reset_n,
    // pass parameters
    input  logic                  pass_start,
    input  layer_type_e           pass_layer_type,
    input  logic [FLAG_WIDTH-1:0] pass_flags,
    input  logic [DIM_WIDTH-1:0]  out_c,
    input  logic [DIM_WIDTH-1:0]  out_r,
    input  logic [ADDR_WIDTH-1:0] base_weight,
    input  logic [ADDR_WIDTH-1:0] base_bias,
    input  logic [ADDR_WIDTH-1:0] base_ifmap,
    input  logic [ADDR_WIDTH-1:0] base_opsum,
    // glb read
    output logic [ADDR_WIDTH-1:0] glb_read_addr,
    output logic                  glb_read_ready,
    input  logic                  glb_read_valid,
    input  logic [DATA_WIDTH-1:0] glb_read_data,
    // glb write
    output logic [ADDR_WIDTH-1:0] glb_write_addr,
    output logic [DATA_WIDTH-1:0] glb_write_data,
    output logic                  glb_write_ready,
    input  logic                  glb_write_valid,
    // pe array
    output logic [DATA_WIDTH-1:0] token_data,
    output logic                  pe_weight_valid,
    input  logic                  pe_weight_ready,
    output logic                  pe_bias_valid,
    input  logic                  pe_bias_ready,
    output logic                  pe_ifmap_valid,
    input  logic                  pe_ifmap_ready,
    // psum buffer
    input  logic [DATA_WIDTH-1:0] pe_psum_data,
    input  logic                  pe_psum_valid,
    output logic                  pe_psum_ready,
    output logic                  pass_done
);

    pass_cfg_if cfg_bus ();

    logic row_start;  // sequencer -> writeback
    logic row_done;   // writeback -> sequencer

    pass_config u_cfg (
        .clk, .reset_n, .pass_start, .pass_done,
        .pass_layer_type, .pass_flags, .out_c, .out_r,
        .base_weight, .base_bias, .base_ifmap, .base_opsum,
        .cfg (cfg_bus.cfg_src)
    );

    token_sequencer u_seq (
        .clk, .reset_n, .pass_start,
        .cfg (cfg_bus.seq_sink),
        .glb_read_addr, .glb_read_ready, .glb_read_valid, .glb_read_data,
        .token_data,
        .pe_weight_valid, .pe_weight_ready,
        .pe_bias_valid, .pe_bias_ready,
        .pe_ifmap_valid, .pe_ifmap_ready,
        .row_start, .row_done, .pass_done
    );

    psum_writeback u_wb (
        .clk, .reset_n, .row_start, .pass_done,
        .cfg (cfg_bus.wb_sink),
        .pe_psum_data, .pe_psum_valid, .pe_psum_ready,
        .glb_write_addr, .glb_write_data, .glb_write_ready, .glb_write_valid,
        .row_done
    );

endmodule

// File: token_sequencer.sv
// weight, bias and ifmap token sequencer
`timescale 1ns/10ps

module token_sequencer import te_params_pkg::*, te_types_pkg::*; (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  pass_start,
    pass_cfg_if.seq_sink          cfg,
    // glb read
    output logic [ADDR_WIDTH-1:0] glb_read_addr,
    output logic                  glb_read_ready,   // request, held until valid
    input  logic                  glb_read_valid,
    input  logic [DATA_WIDTH-1:0] glb_read_data,
    // pe push
    output logic [DATA_WIDTH-1:0] token_data,
    output logic                  pe_weight_valid,
    input  logic                  pe_weight_ready,
    output logic                  pe_bias_valid,
    input  logic                  pe_bias_ready,
    output logic                  pe_ifmap_valid,
    input  logic                  pe_ifmap_ready,
    // row strobes with writeback
    output logic                  row_start,
    input  logic                  row_done,
    output logic                  pass_done
);

    seq_state_e            state;
    seq_state_e            state_nxt;
    logic [CNT_WIDTH-1:0]  tok_cnt;    // tokens done in current phase / row
    logic [ADDR_WIDTH-1:0] ifmap_cnt;  // runs on across rows
    logic [DIM_WIDTH-1:0]  row_cnt;
    logic                  tok_last;
    logic                  row_last;
    logic                  pushed;     // push accepted this edge

    // ifmap phase counts packs, weight / bias phases count tile_k
    assign tok_last = (state == seq_push_ifmap) ? (tok_cnt == cfg.ifmap_packs - 1'b1)
                                                : (tok_cnt == cfg.tile_k - 1'b1);
    assign row_last = (row_cnt == cfg.out_r - 1'b1);

    assign pushed = (pe_weight_valid && pe_weight_ready) ||
                    (pe_bias_valid && pe_bias_ready) ||
                    (pe_ifmap_valid && pe_ifmap_ready);

    // ========================================
    // next state
    // ========================================
    always_comb begin
        state_nxt = state;
        case (state)
            seq_idle: begin
                if (pass_start) state_nxt = seq_read_weight;  // other states ignore it
            end
            seq_read_weight: begin
                if (glb_read_valid) state_nxt = seq_push_weight;
            end
            seq_push_weight: begin
                if (pe_weight_ready) begin
                    if (!tok_last) state_nxt = seq_read_weight;
                    else if (cfg.bias_en) state_nxt = seq_read_bias;
                    else state_nxt = seq_read_ifmap;  // no bias phase
                end
            end
            seq_read_bias: begin
                if (glb_read_valid) state_nxt = seq_push_bias;
            end
            seq_push_bias: begin
                if (pe_bias_ready) state_nxt = tok_last ? seq_read_ifmap : seq_read_bias;
            end
            seq_read_ifmap: begin
                if (glb_read_valid) state_nxt = seq_push_ifmap;
            end
            seq_push_ifmap: begin
                if (pe_ifmap_ready) state_nxt = tok_last ? seq_wait_row : seq_read_ifmap;
            end
            seq_wait_row: begin
                // writeback drains out_c words, then next row or finish
                if (row_done) state_nxt = row_last ? seq_pass_done : seq_read_ifmap;
            end
            seq_pass_done: state_nxt = seq_idle;
            default:       state_nxt = seq_idle;
        endcase
    end

    // ========================================
    // state and counters
    // ========================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state     <= seq_idle;
            tok_cnt   <= '0;
            ifmap_cnt <= '0;
            row_cnt   <= '0;
            row_start <= 1'b0;
        end else begin
            state     <= state_nxt;
            // pulse once the row's last pack is taken
            row_start <= (state == seq_push_ifmap) && pe_ifmap_ready && tok_last;

            if ((state == seq_idle) && pass_start) begin
                tok_cnt   <= '0;
                ifmap_cnt <= '0;
            end else if (pushed) begin
                tok_cnt <= tok_last ? '0 : tok_cnt + 1'b1;  // wraps at phase / row end
                if (state == seq_push_ifmap) ifmap_cnt <= ifmap_cnt + 1'b1;
            end

            if ((state == seq_idle) && pass_start) begin
                row_cnt <= '0;
            end else if ((state == seq_wait_row) && row_done) begin
                row_cnt <= row_cnt + 1'b1;
            end
        end
    end

    // read word held for the push
    always_ff @(posedge clk) begin
        if (glb_read_ready && glb_read_valid) token_data <= glb_read_data;
    end

    // ========================================
    // outputs
    // ========================================
    assign glb_read_ready = (state == seq_read_weight) ||
                            (state == seq_read_bias) ||
                            (state == seq_read_ifmap);

    // counters only move in push states, so the address stays put while requesting
    always_comb begin
        case (state)
            seq_read_bias:  glb_read_addr = cfg.base_bias + ADDR_WIDTH'(tok_cnt);
            seq_read_ifmap: glb_read_addr = cfg.base_ifmap + ifmap_cnt;
            default:        glb_read_addr = cfg.base_weight + ADDR_WIDTH'(tok_cnt);
        endcase
    end

    assign pe_weight_valid = (state == seq_push_weight);  // one valid at a time
    assign pe_bias_valid   = (state == seq_push_bias);
    assign pe_ifmap_valid  = (state == seq_push_ifmap);
    assign pass_done       = (state == seq_pass_done);

endmodule
